/* dv/gpr_file_props.sv */
// Concurrent checks on the register file top level
// Bound into every gpr_file instance
module gpr_file_props (
  input logic                  forever_cpuclk,
  input logic                  rst,
  input gpr_pkg::gpr_idx_t     src0_idx,
  input gpr_pkg::gpr_data_t    src0_data,
  input gpr_pkg::gpr_data_t    src1_data,
  input gpr_pkg::gpr_data_t    src2_data,
  input gpr_pkg::gpr_wr_ctrl_t wr_ctrl
);

  timeunit 1ns;
  timeprecision 100ps;

  // ----------------------------------------
  // Zero register
  // ----------------------------------------

  zero_read_a : assert property (
    @(posedge forever_cpuclk) (src0_idx == '0) |-> (src0_data == '0)
  ) else $error("Read port 0 returned nonzero data for entry 0");

  // Entry 0 must never be enabled for a write
  no_entry0_write_a : assert property (
    @(posedge forever_cpuclk) !wr_ctrl.en[0]
  ) else $error("Write enable set for entry 0");

  // ----------------------------------------
  // Write control consistency
  // ----------------------------------------

  // Port 1 select only where the entry is written
  sel_in_en_a : assert property (
    @(posedge forever_cpuclk) ((wr_ctrl.sel & ~wr_ctrl.en) == '0)
  ) else $error("Port 1 select set on an entry without write enable");

  // ----------------------------------------
  // Reset
  // ----------------------------------------

  reset_clears_a : assert property (
    @(posedge forever_cpuclk) rst |=>
      ((src0_data == '0) && (src1_data == '0) && (src2_data == '0))
  ) else $error("Read port returned nonzero data right after reset");

endmodule

bind gpr_file gpr_file_props i_gpr_file_props (
  .forever_cpuclk (forever_cpuclk),
  .rst            (rst),
  .src0_idx       (src0_idx),
  .src0_data      (src0_data),
  .src1_data      (src1_data),
  .src2_data      (src2_data),
  .wr_ctrl        (wr_ctrl)
);

/* dv/gpr_file_tb.sv */
`include "gpr_config.svh"

module gpr_file_tb;

  timeunit 1ns;
  timeprecision 100ps;

  logic                 forever_cpuclk;
  logic                 rst;
  gpr_pkg::gpr_wb_req_t wb0_req;
  gpr_pkg::gpr_wb_req_t wb1_req;
  gpr_pkg::gpr_idx_t    src0_idx;
  gpr_pkg::gpr_idx_t    src1_idx;
  gpr_pkg::gpr_idx_t    src2_idx;
  gpr_pkg::gpr_data_t   src0_data;
  gpr_pkg::gpr_data_t   src1_data;
  gpr_pkg::gpr_data_t   src2_data;

  // Expected register contents
  gpr_pkg::gpr_data_t shadow [`GPR_NUM_ENTRIES];

  logic [31:0] lfsr_state;
  string       current_test;
  int          error_count;
  int          check_count;
  int          test_count;
  int          test_start_errors;
  int          wait_cycles;

  gpr_file i_gpr_file (
    .forever_cpuclk (forever_cpuclk),
    .rst            (rst),
    .wb0_req        (wb0_req),
    .wb1_req        (wb1_req),
    .src0_idx       (src0_idx),
    .src1_idx       (src1_idx),
    .src2_idx       (src2_idx),
    .src0_data      (src0_data),
    .src1_data      (src1_data),
    .src2_data      (src2_data)
  );

  // 8 ns clock
  always #4 forever_cpuclk = ~forever_cpuclk;

  // ----------------------------------------
  // Random source
  // ----------------------------------------

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0])
    begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  // One LFSR step per bit taken
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      r = {r[62:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
    return r;
  endfunction

  function automatic gpr_pkg::gpr_idx_t rand_nonzero_idx();
    gpr_pkg::gpr_idx_t idx;
    idx = '0;
    while (idx == '0)
    begin
      idx = gpr_pkg::gpr_idx_t'(rand_bits(`GPR_IDX_W));
    end
    return idx;
  endfunction

  function automatic gpr_pkg::gpr_wb_req_t make_req(
    input logic               vld,
    input gpr_pkg::gpr_idx_t  idx,
    input gpr_pkg::gpr_data_t data
  );
    gpr_pkg::gpr_wb_req_t req;
    req.vld  = vld;
    req.idx  = idx;
    req.data = data;
    return req;
  endfunction

  // ----------------------------------------
  // Compare tasks
  // ----------------------------------------

  task automatic check_data(
    input string              what,
    input gpr_pkg::gpr_data_t expected,
    input gpr_pkg::gpr_data_t actual
  );
    check_count++;
    if (actual !== expected)
    begin
      error_count++;
      $display("FAILED %s %s expected %h actual %h", current_test, what, expected, actual);
    end
  endtask

  // Entry 0 and post-reset reads
  task automatic check_zero(input string what, input gpr_pkg::gpr_data_t actual);
    check_count++;
    if (actual !== '0)
    begin
      error_count++;
      $display("FAILED %s %s expected %h actual %h", current_test, what,
               gpr_pkg::gpr_data_t'(0), actual);
    end
  endtask

  // ----------------------------------------
  // Drive helpers and reference model
  // ----------------------------------------

  // Next drive point, 1 ns after the rising edge
  task automatic step();
    @(posedge forever_cpuclk);
    #1;
  endtask

  // Port 0 first so port 1 wins on the same entry
  task automatic update_shadow(input gpr_pkg::gpr_wb_req_t req0, input gpr_pkg::gpr_wb_req_t req1);
    if (req0.vld && (req0.idx != '0))
    begin
      shadow[req0.idx] = req0.data;
    end
    if (req1.vld && (req1.idx != '0))
    begin
      shadow[req1.idx] = req1.data;
    end
  endtask

  task automatic apply_write(input gpr_pkg::gpr_wb_req_t req0, input gpr_pkg::gpr_wb_req_t req1);
    step();
    wb0_req = req0;
    wb1_req = req1;
    step();
    update_shadow(req0, req1);
    wb0_req = '0;
    wb1_req = '0;
  endtask

  task automatic read_ports(
    input gpr_pkg::gpr_idx_t idx0,
    input gpr_pkg::gpr_idx_t idx1,
    input gpr_pkg::gpr_idx_t idx2
  );
    step();
    src0_idx = idx0;
    src1_idx = idx1;
    src2_idx = idx2;
    #2;
    check_data("src0", shadow[idx0], src0_data);
    check_data("src1", shadow[idx1], src1_data);
    check_data("src2", shadow[idx2], src2_data);
  endtask

  task automatic begin_test(input string name);
    current_test = name;
    test_start_errors = error_count;
    test_count++;
  endtask

  task automatic end_test();
    if (error_count == test_start_errors)
    begin
      $display("PASS: %s", current_test);
    end
    else
    begin
      $display("FAIL: %s, %0d errors", current_test, error_count - test_start_errors);
    end
  endtask

  // ----------------------------------------
  // Directed tests
  // ----------------------------------------

  task automatic test_reset_reads();
    begin_test("reset_reads");
    for (int i = 0; i < `GPR_NUM_ENTRIES; i++)
    begin
      step();
      src0_idx = gpr_pkg::gpr_idx_t'(i);
      src1_idx = gpr_pkg::gpr_idx_t'(i);
      src2_idx = gpr_pkg::gpr_idx_t'(i);
      #2;
      check_zero("src0", src0_data);
      check_zero("src1", src1_data);
      check_zero("src2", src2_data);
    end
    end_test();
  endtask

  task automatic test_single_port_writes();
    gpr_pkg::gpr_idx_t idx;
    begin_test("single_port_writes");
    for (int i = 0; i < 16; i++)
    begin
      idx = rand_nonzero_idx();
      // First half on port 0, second half on port 1
      if (i < 8)
      begin
        apply_write(make_req(1'b1, idx, rand_bits(64)), '0);
      end
      else
      begin
        apply_write('0, make_req(1'b1, idx, rand_bits(64)));
      end
      read_ports(idx, idx, idx);
    end
    end_test();
  endtask

  task automatic test_collisions();
    gpr_pkg::gpr_idx_t idx_a;
    gpr_pkg::gpr_idx_t idx_b;
    gpr_pkg::gpr_data_t data1;
    begin_test("collisions");
    for (int i = 0; i < 6; i++)
    begin
      // Same entry on both ports
      idx_a = rand_nonzero_idx();
      data1 = rand_bits(64);
      apply_write(make_req(1'b1, idx_a, rand_bits(64)), make_req(1'b1, idx_a, data1));
      read_ports(idx_a, idx_a, idx_a);
      check_data("port1_wins", data1, src0_data);
      // Two different entries
      idx_b = rand_nonzero_idx();
      while (idx_b == idx_a)
      begin
        idx_b = rand_nonzero_idx();
      end
      apply_write(make_req(1'b1, idx_a, rand_bits(64)), make_req(1'b1, idx_b, rand_bits(64)));
      read_ports(idx_a, idx_b, idx_a);
    end
    end_test();
  endtask

  task automatic test_entry_zero();
    begin_test("entry_zero");
    apply_write(make_req(1'b1, '0, rand_bits(64)), '0);
    read_ports('0, '0, '0);
    check_zero("port0_write", src0_data);
    apply_write('0, make_req(1'b1, '0, rand_bits(64)));
    read_ports('0, '0, '0);
    check_zero("port1_write", src1_data);
    apply_write(make_req(1'b1, '0, rand_bits(64)), make_req(1'b1, '0, rand_bits(64)));
    read_ports('0, '0, '0);
    check_zero("both_write", src2_data);
    end_test();
  endtask

  task automatic test_independent_reads();
    gpr_pkg::gpr_idx_t idx0;
    gpr_pkg::gpr_idx_t idx1;
    gpr_pkg::gpr_idx_t idx2;
    begin_test("independent_reads");
    // Give every entry a distinct value first
    for (int i = 1; i < `GPR_NUM_ENTRIES; i++)
    begin
      apply_write(make_req(1'b1, gpr_pkg::gpr_idx_t'(i), rand_bits(64)), '0);
    end
    for (int i = 0; i < 12; i++)
    begin
      idx0 = gpr_pkg::gpr_idx_t'(rand_bits(`GPR_IDX_W));
      idx1 = gpr_pkg::gpr_idx_t'(rand_bits(`GPR_IDX_W));
      idx2 = gpr_pkg::gpr_idx_t'(rand_bits(`GPR_IDX_W));
      read_ports(idx0, idx1, idx2);
    end
    end_test();
  endtask

  task automatic test_read_during_write();
    gpr_pkg::gpr_idx_t    idx;
    gpr_pkg::gpr_wb_req_t req;
    begin_test("read_during_write");
    for (int i = 0; i < 6; i++)
    begin
      idx = rand_nonzero_idx();
      req = make_req(1'b1, idx, rand_bits(64));
      step();
      wb1_req  = req;
      src0_idx = idx;
      src1_idx = idx;
      src2_idx = idx;
      #2;
      check_data("old_value", shadow[idx], src0_data);
      step();
      update_shadow('0, req);
      wb1_req = '0;
      #2;
      check_data("new_value", req.data, src1_data);
      check_data("new_value", shadow[idx], src2_data);
    end
    end_test();
  endtask

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------

  initial
  begin
    forever_cpuclk = 1'b0;
    rst            = 1'b1;
    wb0_req        = '0;
    wb1_req        = '0;
    src0_idx       = '0;
    src1_idx       = '0;
    src2_idx       = '0;
    repeat (10) @(posedge forever_cpuclk);
    #1;
    rst = 1'b0;
  end

  initial
  begin
    lfsr_state  = 32'hd7362678;
    error_count = 0;
    check_count = 0;
    test_count  = 0;
    wait_cycles = 0;
    for (int i = 0; i < `GPR_NUM_ENTRIES; i++)
    begin
      shadow[i] = '0;
    end
    while ((rst !== 1'b0) && (wait_cycles < 100))
    begin
      @(posedge forever_cpuclk);
      wait_cycles++;
    end
    if (rst !== 1'b0)
    begin
      $display("Reset was not released within 100 cycles");
      $display("Test failures found");
      $finish;
    end
    else
    begin
      test_reset_reads();
      test_single_port_writes();
      test_collisions();
      test_entry_zero();
      test_independent_reads();
      test_read_during_write();
      $display("Tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
      if (error_count == 0)
      begin
        $display("All tests passed!");
      end
      else
      begin
        $display("Test failures found");
      end
      $finish;
    end
  end

endmodule

/* src.f */
+incdir+verilog
verilog/gpr_pkg.sv
verilog/gpr_wb_ctrl.sv
verilog/gpr_entry_array.sv
verilog/gpr_read_mux.sv
verilog/gpr_file.sv
dv/gpr_file_props.sv
dv/gpr_file_tb.sv

/* verilog/gpr_config.svh */
`ifndef GPR_CONFIG_SVH
`define GPR_CONFIG_SVH

// ----------------------------------------
// Register file geometry
// ----------------------------------------

// Architectural integer registers
// Entry 0 is the hardwired zero register
`define GPR_NUM_ENTRIES 32

// Register width for a 64-bit core
`define GPR_XLEN 64

// Index width, log2 of the entry count
`define GPR_IDX_W 5

// ----------------------------------------
// Port counts
// ----------------------------------------

// Operand read ports seen by decode
`define GPR_NUM_READ 3

`endif

/* verilog/gpr_entry_array.sv */
`include "gpr_config.svh"

// Storage for the architectural registers
// Entries 1 to 31 are enabled flops, entry 0 is tied to zero
module gpr_entry_array (
  input  logic                  forever_cpuclk,
  input  logic                  rst,
  input  gpr_pkg::gpr_wr_ctrl_t wr_ctrl,
  input  gpr_pkg::gpr_data_t    wb0_data,
  input  gpr_pkg::gpr_data_t    wb1_data,
  output gpr_pkg::gpr_bank_t    bank
);

  // Writable entries only, index 0 does not exist here
  gpr_pkg::gpr_data_t [`GPR_NUM_ENTRIES-1:1] entry_q;
  gpr_pkg::gpr_data_t [`GPR_NUM_ENTRIES-1:1] entry_d;

  // ----------------------------------------
  // Next value per entry
  // ----------------------------------------

  // Port 1 data when its hit is set, else port 0
  always_comb
  begin
    for (int i = 1; i < `GPR_NUM_ENTRIES; i++)
    begin
      if (wr_ctrl.sel[i])
      begin
        entry_d[i] = wb1_data;
      end
      else
      begin
        entry_d[i] = wb0_data;
      end
    end
  end

  // ----------------------------------------
  // Entry registers
  // ----------------------------------------

  always_ff @(posedge forever_cpuclk)
  begin
    if (rst)
    begin
      entry_q <= '0;
    end
    else
    begin
      for (int i = 1; i < `GPR_NUM_ENTRIES; i++)
      begin
        // Load only on an enabled entry
        if (wr_ctrl.en[i])
        begin
          entry_q[i] <= entry_d[i];
        end
      end
    end
  end

  // ----------------------------------------
  // Bank output
  // ----------------------------------------

  // Entry 0 reads as constant zero
  assign bank = {entry_q, `GPR_XLEN'(0)};

endmodule

/* verilog/gpr_file.sv */
`include "gpr_config.svh"

// Integer register file for the decode stage
// Two write-back ports, three combinational read ports
module gpr_file (
  input  logic                 forever_cpuclk,
  input  logic                 rst,
  input  gpr_pkg::gpr_wb_req_t wb0_req,
  input  gpr_pkg::gpr_wb_req_t wb1_req,
  input  gpr_pkg::gpr_idx_t    src0_idx,
  input  gpr_pkg::gpr_idx_t    src1_idx,
  input  gpr_pkg::gpr_idx_t    src2_idx,
  output gpr_pkg::gpr_data_t   src0_data,
  output gpr_pkg::gpr_data_t   src1_data,
  output gpr_pkg::gpr_data_t   src2_data
);

  gpr_pkg::gpr_wr_ctrl_t                     wr_ctrl;
  gpr_pkg::gpr_bank_t                        bank;
  gpr_pkg::gpr_idx_t  [`GPR_NUM_READ-1:0]    src_idx;
  gpr_pkg::gpr_data_t [`GPR_NUM_READ-1:0]    src_data;

  // ----------------------------------------
  // Write path
  // ----------------------------------------

  gpr_wb_ctrl x_gpr_wb_ctrl (
    .wb0_req (wb0_req),
    .wb1_req (wb1_req),
    .wr_ctrl (wr_ctrl)
  );

  gpr_entry_array x_gpr_entry_array (
    .forever_cpuclk (forever_cpuclk),
    .rst            (rst),
    .wr_ctrl        (wr_ctrl),
    .wb0_data       (wb0_req.data),
    .wb1_data       (wb1_req.data),
    .bank           (bank)
  );

  // ----------------------------------------
  // Read ports
  // ----------------------------------------

  // Source 0 in the low slice
  assign src_idx = {src2_idx, src1_idx, src0_idx};

  for (genvar p = 0; p < `GPR_NUM_READ; p++)
  begin : gen_read
    gpr_read_mux x_gpr_read_mux (
      .bank (bank),
      .idx  (src_idx[p]),
      .data (src_data[p])
    );
  end

  assign src0_data = src_data[0];
  assign src1_data = src_data[1];
  assign src2_data = src_data[2];

endmodule

/* verilog/gpr_pkg.sv */
`include "gpr_config.svh"

package gpr_pkg;

  // ----------------------------------------
  // Scalar types
  // ----------------------------------------

  // Register index as seen by decode and write-back
  typedef logic [`GPR_IDX_W-1:0] gpr_idx_t;

  // One register value
  typedef logic [`GPR_XLEN-1:0] gpr_data_t;

  // One bit per architectural entry
  typedef logic [`GPR_NUM_ENTRIES-1:0] gpr_entry_vec_t;

  // ----------------------------------------
  // Write-back request and control
  // ----------------------------------------

  // Write request from one write-back port
  typedef struct packed {
    logic      vld;
    gpr_idx_t  idx;
    gpr_data_t data;
  } gpr_wb_req_t;

  // Decoded per-entry write control
  // sel picks port 1 data for an entry
  typedef struct packed {
    gpr_entry_vec_t en;
    gpr_entry_vec_t sel;
  } gpr_wr_ctrl_t;

  // All entries' current values, entry 0 in the low slice
  typedef gpr_data_t [`GPR_NUM_ENTRIES-1:0] gpr_bank_t;

endpackage

/* verilog/gpr_read_mux.sv */
`include "gpr_config.svh"

// One operand read port
// Purely combinational selection of the indexed entry
module gpr_read_mux (
  input  gpr_pkg::gpr_bank_t bank,
  input  gpr_pkg::gpr_idx_t  idx,
  output gpr_pkg::gpr_data_t data
);

  // ----------------------------------------
  // Entry select
  // ----------------------------------------

  // AND-OR style select over all entries
  // Exactly one entry matches any index value
  always_comb
  begin
    data = '0;
    for (int i = 0; i < `GPR_NUM_ENTRIES; i++)
    begin
      if (idx == gpr_pkg::gpr_idx_t'(i))
      begin
        data = bank[i];
      end
    end
  end

endmodule

/* verilog/gpr_wb_ctrl.sv */
`include "gpr_config.svh"

// Write-back decode for the two write ports
// Turns each request into a per-entry hit vector and merges them
module gpr_wb_ctrl (
  input  gpr_pkg::gpr_wb_req_t  wb0_req,
  input  gpr_pkg::gpr_wb_req_t  wb1_req,
  output gpr_pkg::gpr_wr_ctrl_t wr_ctrl
);

  // ----------------------------------------
  // Request decode
  // ----------------------------------------

  // One-hot hit of a valid request
  // Entry 0 never gets a hit so the zero register is never written
  function automatic gpr_pkg::gpr_entry_vec_t decode_req(
    input gpr_pkg::gpr_wb_req_t req
  );
    gpr_pkg::gpr_entry_vec_t hit;
    hit = '0;
    for (int i = 1; i < `GPR_NUM_ENTRIES; i++)
    begin
      if (req.vld && (req.idx == gpr_pkg::gpr_idx_t'(i)))
      begin
        hit[i] = 1'b1;
      end
    end
    return hit;
  endfunction

  gpr_pkg::gpr_entry_vec_t wb0_hit;
  gpr_pkg::gpr_entry_vec_t wb1_hit;

  assign wb0_hit = decode_req(wb0_req);
  assign wb1_hit = decode_req(wb1_req);

  // ----------------------------------------
  // Merge and priority
  // ----------------------------------------

  // Any port hitting an entry enables it
  // Port 1 hit selects port 1 data, which also settles a collision
  always_comb
  begin
    wr_ctrl.en  = wb0_hit | wb1_hit;
    wr_ctrl.sel = wb1_hit;
  end

endmodule
